// File: hw/dma_ram_config.svh
// DMA RAM configuration

`ifndef DMA_RAM_CONFIG_SVH
`define DMA_RAM_CONFIG_SVH

// ---------------------------------------------------------------------------
// Segment layout
// ---------------------------------------------------------------------------

// Number of independent segments
`define DMA_RAM_SEGS 2

`define DMA_RAM_SEG_DATA_W 32   // Data bits per segment
`define DMA_RAM_SEG_BE_W 4      // Byte enables per segment, data width / 8
`define DMA_RAM_SEG_ADDR_W 10   // Command address width per segment

// ---------------------------------------------------------------------------
// Storage and read path
// ---------------------------------------------------------------------------

// Total RAM size in bytes, spread over all segments
`define DMA_RAM_SIZE 2048

// Default depth of the read response pipeline
// The memory output register counts as the first stage
`define DMA_RAM_RD_PIPELINE 2

`endif

// File: hw/dma_ram_pkg.sv
// DMA RAM shared types

`include "dma_ram_config.svh"
`default_nettype none

package dma_ram_pkg;

    // -----------------------------------------------------------------------
    // Per-segment command fields
    // -----------------------------------------------------------------------

    // One data word of a segment
    typedef logic [`DMA_RAM_SEG_DATA_W-1:0] seg_data_t;

    typedef logic [`DMA_RAM_SEG_BE_W-1:0] seg_be_t;      // One bit per data byte
    typedef logic [`DMA_RAM_SEG_ADDR_W-1:0] seg_addr_t;  // Row address as issued by DMA

    // -----------------------------------------------------------------------
    // Derived storage geometry
    // -----------------------------------------------------------------------

    // Row address bits actually decoded by each segment array
    // Each row holds one word per segment, so the byte size splits across
    // segments times bytes per word
    localparam int INT_ADDR_W =
        $clog2(`DMA_RAM_SIZE / (`DMA_RAM_SEGS * `DMA_RAM_SEG_BE_W));

endpackage

`default_nettype wire

// File: hw/dma_ram_seg_mem.sv
// DMA RAM segment storage

`default_nettype none

module dma_ram_seg_mem (
    // Write port
    input  logic                   clk_wr,
    input  logic                   rst_wr,
    input  logic                   wr_cmd_valid,
    input  dma_ram_pkg::seg_addr_t wr_cmd_addr,
    input  dma_ram_pkg::seg_be_t   wr_cmd_be,
    input  dma_ram_pkg::seg_data_t wr_cmd_data,
    output logic                   wr_done,

    // Read port, stage 0 of the response pipeline
    input  logic                   clk_rd,
    input  logic                   rd_en,
    input  dma_ram_pkg::seg_addr_t rd_addr,
    output dma_ram_pkg::seg_data_t rd_stage0_data
);

    localparam int ROW_W  = dma_ram_pkg::INT_ADDR_W;
    localparam int ROWS   = 2 ** ROW_W;
    localparam int ADDR_W = $bits(dma_ram_pkg::seg_addr_t);
    localparam int BE_W   = $bits(dma_ram_pkg::seg_be_t);

    // The command address must be able to reach every row
    if (ADDR_W < ROW_W) begin : g_addr_check
        $fatal(1, "Segment address width %0d too small, need %0d rows bits",
               ADDR_W, ROW_W);
    end

    // -----------------------------------------------------------------------
    // Storage array
    // -----------------------------------------------------------------------

    dma_ram_pkg::seg_data_t mem [ROWS] = '{default: '0};  // Cleared at power-up

    logic [ROW_W-1:0] wr_row;
    logic [ROW_W-1:0] rd_row;

    assign wr_row = wr_cmd_addr[ROW_W-1:0];  // Upper bits ignored
    assign rd_row = rd_addr[ROW_W-1:0];

    // -----------------------------------------------------------------------
    // Write side, clk_wr domain
    // -----------------------------------------------------------------------

    // Byte-lane write, only enabled lanes change
    always_ff @(posedge clk_wr) begin
        for (int i = 0; i < BE_W; i++) begin
            if (wr_cmd_valid && wr_cmd_be[i]) begin
                mem[wr_row][i*8 +: 8] <= wr_cmd_data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_wr) begin
        if (rst_wr) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= wr_cmd_valid;  // One pulse per accepted command
        end
    end

    // -----------------------------------------------------------------------
    // Read side, clk_rd domain
    // -----------------------------------------------------------------------

    // Output register only loads on an accepted command, so it holds
    // stage 0 data while the pipe is stalled
    always_ff @(posedge clk_rd) begin
        if (rd_en) begin
            rd_stage0_data <= mem[rd_row];
        end
    end

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------

    // DMA engine must keep addresses inside the array
    a_wr_addr_range: assert property (
        @(posedge clk_wr) disable iff (rst_wr)
        wr_cmd_valid |-> ((wr_cmd_addr >> ROW_W) == '0)
    ) else $error("Write address outside segment array");

endmodule

`default_nettype wire

// File: hw/dma_ram_rd_pipe.sv
// DMA RAM read response pipeline

`include "dma_ram_config.svh"
`default_nettype none

module dma_ram_rd_pipe #(
    parameter int PIPELINE = `DMA_RAM_RD_PIPELINE  // Stage count, 1 or more
) (
    input  logic                   clk_rd,
    input  logic                   rst_rd,

    // Read command
    input  logic                   rd_cmd_valid,
    input  dma_ram_pkg::seg_addr_t rd_cmd_addr,
    output logic                   rd_cmd_ready,

    // To the segment storage
    output logic                   rd_en,
    output dma_ram_pkg::seg_addr_t rd_addr,
    input  dma_ram_pkg::seg_data_t rd_stage0_data,

    // Read response
    output logic                   rd_resp_valid,
    output dma_ram_pkg::seg_data_t rd_resp_data,
    input  logic                   rd_resp_ready
);

    if (PIPELINE < 1) begin : g_depth_check
        $fatal(1, "PIPELINE must be at least 1, got %0d", PIPELINE);
    end

    logic [PIPELINE-1:0] valid_q;     // One valid bit per stage, last is output
    logic [PIPELINE-1:0] valid_d;
    logic [PIPELINE-1:0] stage_open;  // Stage k may load from stage k-1

    dma_ram_pkg::seg_data_t stage_data [PIPELINE];

    // -----------------------------------------------------------------------
    // Advance rule
    // -----------------------------------------------------------------------

    // A stage can take new data when the output drains or when it or any
    // stage after it is empty, so bubbles get squeezed out under stall
    always_comb begin
        for (int k = 0; k < PIPELINE; k++) begin
            stage_open[k] = rd_resp_ready || ((~valid_q >> k) != '0);
        end
    end

    assign rd_cmd_ready = stage_open[0];                // Same rule feeds stage 0
    assign rd_en        = rd_cmd_valid && rd_cmd_ready;
    assign rd_addr      = rd_cmd_addr;

    // -----------------------------------------------------------------------
    // Valid bits
    // -----------------------------------------------------------------------

    always_comb begin
        valid_d = valid_q;
        if (rd_resp_ready) begin
            valid_d[PIPELINE-1] = 1'b0;  // Response taken
        end
        // Walk from the output back so a moved stage can be refilled
        for (int k = PIPELINE - 1; k > 0; k--) begin
            if (stage_open[k]) begin
                valid_d[k]   = valid_q[k-1];
                valid_d[k-1] = 1'b0;
            end
        end
        if (rd_en) begin
            valid_d[0] = 1'b1;
        end
    end

    always_ff @(posedge clk_rd) begin
        if (rst_rd) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // -----------------------------------------------------------------------
    // Data stages
    // -----------------------------------------------------------------------

    assign stage_data[0] = rd_stage0_data;  // Held in the storage block

    for (genvar k = 1; k < PIPELINE; k++) begin : g_stage
        dma_ram_pkg::seg_data_t data_q;

        always_ff @(posedge clk_rd) begin
            if (stage_open[k]) begin
                data_q <= stage_data[k-1];
            end
        end

        assign stage_data[k] = data_q;
    end

    assign rd_resp_valid = valid_q[PIPELINE-1];
    assign rd_resp_data  = stage_data[PIPELINE-1];

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------

    // Stalled response must not move or change
    a_resp_hold: assert property (
        @(posedge clk_rd) disable iff (rst_rd)
        (rd_resp_valid && !rd_resp_ready) |=> (rd_resp_valid && $stable(rd_resp_data))
    ) else $error("Read response changed under back-pressure");

    // A full stalled pipe keeps every item and stage 0 is not reloaded
    a_no_overfill: assert property (
        @(posedge clk_rd) disable iff (rst_rd)
        ((&valid_q) && !rd_resp_ready) |=> ((&valid_q) && $stable(rd_stage0_data))
    ) else $error("Read command accepted into a full stalled pipeline");

endmodule

`default_nettype wire

// File: hw/dma_psdpram_async.sv
// DMA segmented dual-port RAM

`include "dma_ram_config.svh"
`default_nettype none

module dma_psdpram_async #(
    parameter int PIPELINE = `DMA_RAM_RD_PIPELINE  // Read response stages
) (
    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    input  logic                                            clk_wr,
    input  logic                                            rst_wr,
    input  logic [`DMA_RAM_SEGS-1:0]                        wr_cmd_valid,
    input  logic [`DMA_RAM_SEGS*`DMA_RAM_SEG_ADDR_W-1:0]    wr_cmd_addr,
    input  logic [`DMA_RAM_SEGS*`DMA_RAM_SEG_BE_W-1:0]      wr_cmd_be,
    input  logic [`DMA_RAM_SEGS*`DMA_RAM_SEG_DATA_W-1:0]    wr_cmd_data,
    output logic [`DMA_RAM_SEGS-1:0]                        wr_done,

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    input  logic                                            clk_rd,
    input  logic                                            rst_rd,
    input  logic [`DMA_RAM_SEGS-1:0]                        rd_cmd_valid,
    input  logic [`DMA_RAM_SEGS*`DMA_RAM_SEG_ADDR_W-1:0]    rd_cmd_addr,
    output logic [`DMA_RAM_SEGS-1:0]                        rd_cmd_ready,
    output logic [`DMA_RAM_SEGS-1:0]                        rd_resp_valid,
    output logic [`DMA_RAM_SEGS*`DMA_RAM_SEG_DATA_W-1:0]    rd_resp_data,
    input  logic [`DMA_RAM_SEGS-1:0]                        rd_resp_ready
);

    localparam int SEGS   = `DMA_RAM_SEGS;
    localparam int ADDR_W = $bits(dma_ram_pkg::seg_addr_t);
    localparam int BE_W   = $bits(dma_ram_pkg::seg_be_t);
    localparam int DATA_W = $bits(dma_ram_pkg::seg_data_t);

    // Segment n sits in slice n of every flattened vector
    for (genvar n = 0; n < SEGS; n++) begin : g_seg
        logic                   rd_en;        // Accept pulse from the pipe
        dma_ram_pkg::seg_addr_t rd_addr;
        dma_ram_pkg::seg_data_t stage0_data;  // Registered array output

        dma_ram_seg_mem u_seg_mem (
            .clk_wr         (clk_wr),
            .rst_wr         (rst_wr),
            .wr_cmd_valid   (wr_cmd_valid[n]),
            .wr_cmd_addr    (wr_cmd_addr[n*ADDR_W +: ADDR_W]),
            .wr_cmd_be      (wr_cmd_be[n*BE_W +: BE_W]),
            .wr_cmd_data    (wr_cmd_data[n*DATA_W +: DATA_W]),
            .wr_done        (wr_done[n]),
            .clk_rd         (clk_rd),
            .rd_en          (rd_en),
            .rd_addr        (rd_addr),
            .rd_stage0_data (stage0_data)
        );

        dma_ram_rd_pipe #(
            .PIPELINE (PIPELINE)
        ) u_rd_pipe (
            .clk_rd         (clk_rd),
            .rst_rd         (rst_rd),
            .rd_cmd_valid   (rd_cmd_valid[n]),
            .rd_cmd_addr    (rd_cmd_addr[n*ADDR_W +: ADDR_W]),
            .rd_cmd_ready   (rd_cmd_ready[n]),
            .rd_en          (rd_en),
            .rd_addr        (rd_addr),
            .rd_stage0_data (stage0_data),
            .rd_resp_valid  (rd_resp_valid[n]),
            .rd_resp_data   (rd_resp_data[n*DATA_W +: DATA_W]),
            .rd_resp_ready  (rd_resp_ready[n])
        );
    end

endmodule

`default_nettype wire

// File: sim/tb_dma_psdpram_async.sv
// DMA RAM directed testbench

`include "dma_ram_config.svh"
`default_nettype none

module tb_dma_psdpram_async;

    localparam int SEGS     = `DMA_RAM_SEGS;
    localparam int ADDR_W   = `DMA_RAM_SEG_ADDR_W;
    localparam int BE_W     = `DMA_RAM_SEG_BE_W;
    localparam int DATA_W   = `DMA_RAM_SEG_DATA_W;
    localparam int ROWS     = 2 ** dma_ram_pkg::INT_ADDR_W;
    localparam int PIPELINE = `DMA_RAM_RD_PIPELINE;
    localparam int TIMEOUT  = 100;                   // Cycles per wait loop

    logic                   clk_wr;
    logic                   rst_wr;
    logic [SEGS-1:0]        wr_cmd_valid;
    logic [SEGS*ADDR_W-1:0] wr_cmd_addr;
    logic [SEGS*BE_W-1:0]   wr_cmd_be;
    logic [SEGS*DATA_W-1:0] wr_cmd_data;
    logic [SEGS-1:0]        wr_done;
    logic                   clk_rd;
    logic                   rst_rd;
    logic [SEGS-1:0]        rd_cmd_valid;
    logic [SEGS*ADDR_W-1:0] rd_cmd_addr;
    logic [SEGS-1:0]        rd_cmd_ready;
    logic [SEGS-1:0]        rd_resp_valid;
    logic [SEGS*DATA_W-1:0] rd_resp_data;
    logic [SEGS-1:0]        rd_resp_ready;

    dma_ram_pkg::seg_data_t model [SEGS][ROWS];  // Expected RAM contents
    integer seed;
    int     pass_count;
    int     fail_count;

    dma_psdpram_async #(
        .PIPELINE (PIPELINE)
    ) u_dma_psdpram_async (
        .clk_wr        (clk_wr),
        .rst_wr        (rst_wr),
        .wr_cmd_valid  (wr_cmd_valid),
        .wr_cmd_addr   (wr_cmd_addr),
        .wr_cmd_be     (wr_cmd_be),
        .wr_cmd_data   (wr_cmd_data),
        .wr_done       (wr_done),
        .clk_rd        (clk_rd),
        .rst_rd        (rst_rd),
        .rd_cmd_valid  (rd_cmd_valid),
        .rd_cmd_addr   (rd_cmd_addr),
        .rd_cmd_ready  (rd_cmd_ready),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_data  (rd_resp_data),
        .rd_resp_ready (rd_resp_ready)
    );

    always #5 clk_rd = ~clk_rd;

    always begin
        #3;  // Write clock lags the read clock
        forever #5 clk_wr = ~clk_wr;
    end

    // ------------------------------------------------------------------------
    // Compare tasks and expected-value helpers
    // ------------------------------------------------------------------------

    task automatic check_data(input string what, input dma_ram_pkg::seg_data_t got,
                              input dma_ram_pkg::seg_data_t exp);
        if (got === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Only the enabled byte lanes take the new data
    function automatic dma_ram_pkg::seg_data_t merge_bytes(
        input dma_ram_pkg::seg_data_t old_word,
        input dma_ram_pkg::seg_data_t new_word,
        input dma_ram_pkg::seg_be_t   be
    );
        dma_ram_pkg::seg_data_t result;
        result = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic end_test(input string name);
        $display("test %-16s finished, %0d errors so far", name, fail_count);
    endtask

    task automatic wait_settle();
        repeat (4) @(posedge clk_rd);  // Margin for the write to cross clocks
    endtask

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------

    task automatic write_word(input int seg, input int row, input dma_ram_pkg::seg_be_t be,
                              input dma_ram_pkg::seg_data_t data);
        @(posedge clk_wr);
        #1;
        check_bit("wr_done idle before write", wr_done[seg], 1'b0);
        wr_cmd_valid[seg]                 = 1'b1;
        wr_cmd_addr[seg*ADDR_W +: ADDR_W] = dma_ram_pkg::seg_addr_t'(row);
        wr_cmd_be[seg*BE_W +: BE_W]       = be;
        wr_cmd_data[seg*DATA_W +: DATA_W] = data;
        @(posedge clk_wr);
        #1;
        wr_cmd_valid[seg] = 1'b0;
        check_bit("wr_done pulse after write", wr_done[seg], 1'b1);
        @(posedge clk_wr);
        #1;
        check_bit("wr_done back low after one cycle", wr_done[seg], 1'b0);
        model[seg][row] = merge_bytes(model[seg][row], data, be);
    endtask

    task automatic read_word(input int seg, input int row,
                             output dma_ram_pkg::seg_data_t data);
        int waited;
        @(posedge clk_rd);
        #1;
        rd_cmd_valid[seg]                 = 1'b1;
        rd_cmd_addr[seg*ADDR_W +: ADDR_W] = dma_ram_pkg::seg_addr_t'(row);
        waited = 0;
        while (!rd_cmd_ready[seg] && waited < TIMEOUT) begin
            @(posedge clk_rd);
            #1;
            waited++;
        end
        if (!rd_cmd_ready[seg]) begin
            fail_count++;
            $display("timeout: segment %0d never took the read command", seg);
        end
        @(posedge clk_rd);  // Command accepted here
        #1;
        rd_cmd_valid[seg] = 1'b0;
        waited = 0;
        while (!rd_resp_valid[seg] && waited < TIMEOUT) begin
            @(posedge clk_rd);
            #1;
            waited++;
        end
        if (!rd_resp_valid[seg]) begin
            fail_count++;
            $display("timeout: segment %0d gave no read response", seg);
        end
        data = rd_resp_data[seg*DATA_W +: DATA_W];
        @(posedge clk_rd);  // Response taken, resp_ready is high
        #1;
    endtask

    task automatic read_and_compare(input int seg, input int row);
        dma_ram_pkg::seg_data_t data;
        read_word(seg, row, data);
        check_data($sformatf("read seg %0d row %0d", seg, row), data, model[seg][row]);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic test_reset();
        // Consumer still stalled, so ready can only come from empty stages
        for (int s = 0; s < SEGS; s++) begin
            check_bit("wr_done after reset", wr_done[s], 1'b0);
            check_bit("rd_resp_valid after reset", rd_resp_valid[s], 1'b0);
            check_bit("rd_cmd_ready after reset", rd_cmd_ready[s], 1'b1);
        end
        @(posedge clk_rd);
        #1;
        rd_resp_ready = '1;
        for (int s = 0; s < SEGS; s++) begin
            read_and_compare(s, 0);
            read_and_compare(s, 77);
            read_and_compare(s, ROWS - 1);
        end
        end_test("reset");
    endtask

    task automatic test_full_word();
        for (int s = 0; s < SEGS; s++) begin
            for (int i = 0; i < 6; i++) begin
                write_word(s, (i * 37 + 5) % ROWS, '1, $random(seed));
            end
        end
        wait_settle();
        for (int s = 0; s < SEGS; s++) begin
            for (int i = 0; i < 6; i++) begin
                read_and_compare(s, (i * 37 + 5) % ROWS);
            end
        end
        end_test("full_word");
    endtask

    task automatic test_byte_enables();
        dma_ram_pkg::seg_be_t masks [5] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
        write_word(1, 20, '1, $random(seed));
        wait_settle();
        read_and_compare(1, 20);
        foreach (masks[m]) begin
            write_word(1, 20, masks[m], $random(seed));
            wait_settle();
            read_and_compare(1, 20);
        end
        end_test("byte_enables");
    endtask

    task automatic test_independence();
        dma_ram_pkg::seg_data_t word;
        word = $random(seed);
        write_word(0, 99, '1, word);
        write_word(1, 99, '1, ~word);  // Same row, other data
        wait_settle();
        read_and_compare(0, 99);
        read_and_compare(1, 99);
        end_test("independence");
    endtask

    task automatic test_latency();
        int   issued;
        int   got;
        int   cyc;
        int   first_acc;
        int   first_resp;
        logic accept;
        for (int i = 0; i < 6; i++) begin
            write_word(0, 128 + i, '1, $random(seed));
        end
        wait_settle();
        issued     = 0;
        got        = 0;
        cyc        = 0;
        first_acc  = -1;
        first_resp = -1;
        @(posedge clk_rd);
        #1;
        rd_cmd_valid[0]          = 1'b1;
        rd_cmd_addr[ADDR_W-1:0] = dma_ram_pkg::seg_addr_t'(128);
        while (got < 6 && cyc < TIMEOUT) begin
            accept = rd_cmd_valid[0] && rd_cmd_ready[0];
            if (rd_resp_valid[0]) begin
                if (first_resp < 0) begin
                    first_resp = cyc;
                end
                check_data("back-to-back read data", rd_resp_data[DATA_W-1:0],
                           model[0][128 + got]);
                check_bit("response on consecutive cycle", cyc == first_resp + got, 1'b1);
                got++;
            end
            @(posedge clk_rd);
            #1;
            if (accept) begin
                if (first_acc < 0) begin
                    first_acc = cyc;
                end
                issued++;
            end
            cyc++;
            if (issued < 6) begin
                rd_cmd_addr[ADDR_W-1:0] = dma_ram_pkg::seg_addr_t'(128 + issued);
            end else begin
                rd_cmd_valid[0] = 1'b0;
            end
        end
        rd_cmd_valid[0] = 1'b0;
        if (got < 6) begin
            fail_count++;
            $display("timeout: only %0d of 6 back-to-back responses arrived", got);
        end else begin
            check_bit("first response PIPELINE cycles after accept",
                      (first_resp - first_acc) == PIPELINE, 1'b1);
        end
        end_test("latency");
    endtask

    task automatic test_back_pressure();
        int                     accepts;
        int                     got;
        int                     waited;
        dma_ram_pkg::seg_data_t held;
        for (int i = 0; i < PIPELINE + 2; i++) begin
            write_word(1, 200 + i, '1, $random(seed));
        end
        wait_settle();
        @(posedge clk_rd);
        #1;
        rd_resp_ready[1]              = 1'b0;
        rd_cmd_valid[1]               = 1'b1;
        rd_cmd_addr[ADDR_W +: ADDR_W] = dma_ram_pkg::seg_addr_t'(200);
        accepts = 0;
        while (rd_cmd_ready[1] && accepts < TIMEOUT) begin
            @(posedge clk_rd);
            #1;
            accepts++;
            rd_cmd_addr[ADDR_W +: ADDR_W] = dma_ram_pkg::seg_addr_t'(200 + accepts);
        end
        rd_cmd_valid[1] = 1'b0;
        if (rd_cmd_ready[1]) begin
            fail_count++;
            $display("timeout: read command ready never dropped under back-pressure");
        end
        check_bit("ready falls after PIPELINE accepts", accepts == PIPELINE, 1'b1);
        check_bit("response valid while stalled", rd_resp_valid[1], 1'b1);
        held = rd_resp_data[DATA_W +: DATA_W];
        check_data("stalled response", held, model[1][200]);
        repeat (4) begin
            @(posedge clk_rd);
            #1;
            check_bit("stalled response stays valid", rd_resp_valid[1], 1'b1);
            check_data("stalled response stays stable", rd_resp_data[DATA_W +: DATA_W], held);
            check_bit("ready stays low while full", rd_cmd_ready[1], 1'b0);
        end
        rd_resp_ready[1] = 1'b1;
        got    = 0;
        waited = 0;
        while (got < accepts && waited < TIMEOUT) begin
            if (rd_resp_valid[1]) begin
                check_data("released response order", rd_resp_data[DATA_W +: DATA_W],
                           model[1][(200 + got) % ROWS]);
                got++;
            end
            @(posedge clk_rd);
            #1;
            waited++;
        end
        if (got < accepts) begin
            fail_count++;
            $display("timeout: %0d of %0d held responses came out", got, accepts);
        end
        repeat (3) begin
            check_bit("no duplicate response", rd_resp_valid[1], 1'b0);
            @(posedge clk_rd);
            #1;
        end
        end_test("back_pressure");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed          = 93;
        pass_count    = 0;
        fail_count    = 0;
        clk_rd        = 1'b0;
        clk_wr        = 1'b0;
        rst_rd        = 1'b1;
        rst_wr        = 1'b1;
        wr_cmd_valid  = '0;
        wr_cmd_addr   = '0;
        wr_cmd_be     = '0;
        wr_cmd_data   = '0;
        rd_cmd_valid  = '0;
        rd_cmd_addr   = '0;
        rd_resp_ready = '0;
        for (int s = 0; s < SEGS; s++) begin
            for (int r = 0; r < ROWS; r++) begin
                model[s][r] = '0;  // RAM starts cleared
            end
        end
        fork
            begin
                repeat (3) @(posedge clk_rd);
                #1;
                rst_rd = 1'b0;
            end
            begin
                repeat (3) @(posedge clk_wr);
                #1;
                rst_wr = 1'b0;
            end
        join

        test_reset();
        test_full_word();
        test_byte_enables();
        test_independence();
        test_latency();
        test_back_pressure();

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/dma_ram_pkg.sv
hw/dma_ram_seg_mem.sv
hw/dma_ram_rd_pipe.sv
hw/dma_psdpram_async.sv
sim/tb_dma_psdpram_async.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_psdpram_async -f project.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^PASS: all tests$" sim.log \
    && echo "Simulation passed" \
    && exit 0 \
    || { echo "Simulation failed"; exit 1; }
